// ==== hdl/csr_access_port.sv ====
`default_nettype none

module csr_access_port
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 req,
    input  wire csr_op_e              op,
    input  wire logic [CSR_NUM_W-1:0] num,
    input  wire logic [DATA_W-1:0]    wdata,
    input  wire logic [DATA_W-1:0]    wmask,
    input  wire logic [DATA_W-1:0]    reg_rvalue,
    input  wire logic [DATA_W-1:0]    tmr_rvalue,
    output logic                      ack,
    output logic [DATA_W-1:0]         rdata,
    output logic [CSR_NUM_W-1:0]      acc_num,
    output logic                      acc_we,
    output logic [DATA_W-1:0]         acc_wvalue,
    output logic [DATA_W-1:0]         acc_wmask
);

    logic fire;
    logic is_timer;

    // one access per handshake, on the edge where req is seen first
    assign fire = req && !ack;

    assign is_timer = (num == CSR_TCFG) || (num == CSR_TVAL) || (num == CSR_TICLR);

    assign acc_num    = num;
    assign acc_wvalue = wdata;
    assign acc_we     = fire && (op != CSR_OP_RD);

    // csrwr writes every bit, csrxchg only the masked ones
    always_comb begin
        case (op)
            CSR_OP_WR:   acc_wmask = '1;
            CSR_OP_XCHG: acc_wmask = wmask;
            default:     acc_wmask = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (fire) begin
            ack <= 1'b1;
        end else if (!req) begin
            ack <= 1'b0;
        end
    end

    // old value, captured before the write lands
    always_ff @(posedge clk) begin
        if (fire) begin
            rdata <= is_timer ? tmr_rvalue : reg_rvalue;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_map_pkg.sv ====
`default_nettype none

package csr_map_pkg;

    // csr numbers
    localparam int CSR_NUM_W = 14;

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h7;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'hc;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h31;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h32;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h33;
    localparam logic [CSR_NUM_W-1:0] CSR_LLBCTL = 14'h60;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h40;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h44;

    // field widths
    localparam int DATA_W = 32;
    localparam int LIE_W  = 13;
    localparam int HWI_W  = 8;

    // timer pending bit inside estat.is
    localparam int TIMER_IS_BIT = 11;

    // eentry holds a 64-byte aligned vector
    localparam int EENTRY_LSB = 6;

    // counter value of a stopped timer
    localparam logic [DATA_W-1:0] TVAL_IDLE = '1;

endpackage

`default_nettype wire

// ==== hdl/csr_regfile.sv ====
`default_nettype none

module csr_regfile
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [CSR_NUM_W-1:0]  acc_num,
    input  wire logic                  acc_we,
    input  wire logic [DATA_W-1:0]     acc_wvalue,
    input  wire logic [DATA_W-1:0]     acc_wmask,
    input  wire logic                  wb_ex,
    input  wire logic [ECODE_W-1:0]    wb_ecode,
    input  wire logic [ESUBCODE_W-1:0] wb_esubcode,
    input  wire logic [DATA_W-1:0]     wb_pc,
    input  wire logic [DATA_W-1:0]     wb_vaddr,
    input  wire logic                  ertn_flush,
    input  wire logic [HWI_W-1:0]      hw_int,
    input  wire logic [DATA_W-1:0]     core_id,
    input  wire logic                  timer_irq,
    output logic [DATA_W-1:0]          reg_rvalue,
    output logic                       crmd_ie,
    output logic [DATA_W-1:0]          era,
    output logic [DATA_W-1:0]          eentry,
    output logic [LIE_W-1:0]           estat_is_lie
);

    logic [1:0]                 crmd_plv;
    logic [1:0]                 prmd_pplv;
    logic                       prmd_pie;
    logic [LIE_W-1:0]           ecfg_lie;
    logic [1:0]                 is_sw;
    logic [HWI_W-1:0]           is_hw;
    logic [ECODE_W-1:0]         estat_ecode;
    logic [ESUBCODE_W-1:0]      estat_esubcode;
    logic [DATA_W-1:0]          badv;
    logic [DATA_W-1:EENTRY_LSB] eentry_va;
    logic [DATA_W-1:0]          save_q [4];
    logic                       llbctl_klo;
    logic [DATA_W-1:0]          tid;

    logic [LIE_W-1:0]  estat_is;
    logic [DATA_W-1:0] crmd_r, prmd_r, ecfg_r, estat_r, llbctl_r;
    logic [DATA_W-1:0] crmd_nx, prmd_nx, ecfg_nx, estat_nx, eentry_nx, llbctl_nx;
    logic              is_adef;
    logic              is_ale;

    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old);
        return (acc_wmask & acc_wvalue) | (~acc_wmask & old);
    endfunction

    // assembled register views, reserved bits are zero
    always_comb begin
        estat_is = '0;
        estat_is[1:0] = is_sw;
        estat_is[2 +: HWI_W] = is_hw;
        estat_is[TIMER_IS_BIT] = timer_irq;
    end

    assign crmd_r   = {28'b0, 1'b1, crmd_ie, crmd_plv};
    assign prmd_r   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_r   = {{(DATA_W - LIE_W){1'b0}}, ecfg_lie};
    assign estat_r  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry   = {eentry_va, {EENTRY_LSB{1'b0}}};
    assign llbctl_r = {29'b0, llbctl_klo, 2'b0};

    assign crmd_nx   = merge(crmd_r);
    assign prmd_nx   = merge(prmd_r);
    assign ecfg_nx   = merge(ecfg_r);
    assign estat_nx  = merge(estat_r);
    assign eentry_nx = merge(eentry);
    assign llbctl_nx = merge(llbctl_r);

    assign is_adef = (wb_ecode == ECODE_ADE) && (wb_esubcode == ESUB_ADEF);
    assign is_ale  = (wb_ecode == ECODE_ALE);

    // crmd: trap, then ertn, then software
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (acc_we && acc_num == CSR_CRMD) begin
            crmd_plv <= crmd_nx[1:0];
            crmd_ie  <= crmd_nx[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv  <= 2'b0;
            prmd_pie   <= 1'b0;
            ecfg_lie   <= '0;
            is_sw      <= 2'b0;
            is_hw      <= '0;
            llbctl_klo <= 1'b0;
            tid        <= core_id;
        end else begin
            if (wb_ex) begin
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
            end else if (acc_we && acc_num == CSR_PRMD) begin
                prmd_pplv <= prmd_nx[1:0];
                prmd_pie  <= prmd_nx[2];
            end
            // bit 10 is reserved
            if (acc_we && acc_num == CSR_ECFG) begin
                ecfg_lie <= {ecfg_nx[12:11], 1'b0, ecfg_nx[9:0]};
            end
            if (acc_we && acc_num == CSR_ESTAT) begin
                is_sw <= estat_nx[1:0];
            end
            // hardware lines sampled every cycle
            is_hw <= hw_int;
            // only klo is kept
            if (acc_we && acc_num == CSR_LLBCTL) begin
                llbctl_klo <= llbctl_nx[2];
            end
            if (acc_we && acc_num == CSR_TID) begin
                tid <= merge(tid);
            end
        end
    end

    // exception payload
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era            <= wb_pc;
        end else if (acc_we && acc_num == CSR_ERA) begin
            era <= merge(era);
        end
        if (wb_ex && (is_adef || is_ale)) begin
            badv <= is_adef ? wb_pc : wb_vaddr;
        end else if (!wb_ex && acc_we && acc_num == CSR_BADV) begin
            badv <= merge(badv);
        end
        if (acc_we && acc_num == CSR_EENTRY) begin
            eentry_va <= eentry_nx[DATA_W-1:EENTRY_LSB];
        end
        for (int i = 0; i < 4; i++) begin
            if (acc_we && acc_num == CSR_SAVE0 + CSR_NUM_W'(i)) begin
                save_q[i] <= merge(save_q[i]);
            end
        end
    end

    always_comb begin
        case (acc_num)
            CSR_CRMD:   reg_rvalue = crmd_r;
            CSR_PRMD:   reg_rvalue = prmd_r;
            CSR_ECFG:   reg_rvalue = ecfg_r;
            CSR_ESTAT:  reg_rvalue = estat_r;
            CSR_ERA:    reg_rvalue = era;
            CSR_BADV:   reg_rvalue = badv;
            CSR_EENTRY: reg_rvalue = eentry;
            CSR_SAVE0:  reg_rvalue = save_q[0];
            CSR_SAVE1:  reg_rvalue = save_q[1];
            CSR_SAVE2:  reg_rvalue = save_q[2];
            CSR_SAVE3:  reg_rvalue = save_q[3];
            CSR_LLBCTL: reg_rvalue = llbctl_r;
            CSR_TID:    reg_rvalue = tid;
            default:    reg_rvalue = '0;
        endcase
    end

    assign estat_is_lie = estat_is & ecfg_lie;

endmodule

`default_nettype wire

// ==== hdl/csr_timer.sv ====
`default_nettype none

module csr_timer
    import csr_map_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic [CSR_NUM_W-1:0] acc_num,
    input  wire logic                 acc_we,
    input  wire logic [DATA_W-1:0]    acc_wvalue,
    input  wire logic [DATA_W-1:0]    acc_wmask,
    output logic [DATA_W-1:0]         tmr_rvalue,
    output logic                      timer_irq
);

    logic              tcfg_en;
    logic              tcfg_periodic;
    logic [29:0]       tcfg_initval;
    logic [DATA_W-1:0] tval;

    logic [DATA_W-1:0] tcfg_r;
    logic [DATA_W-1:0] tcfg_nx;
    logic              tcfg_we;
    logic              ticlr_clr;
    logic              counting;

    assign tcfg_r  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_nx = (acc_wmask & acc_wvalue) | (~acc_wmask & tcfg_r);
    assign tcfg_we = acc_we && (acc_num == CSR_TCFG);

    // write 1 to ticlr bit 0 clears the pending flag
    assign ticlr_clr = acc_we && (acc_num == CSR_TICLR) && acc_wmask[0] && acc_wvalue[0];

    assign counting = tcfg_en && (tval != TVAL_IDLE);

    always_ff @(posedge clk) begin
        if (tcfg_we) begin
            tcfg_periodic <= tcfg_nx[1];
            tcfg_initval  <= tcfg_nx[31:2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en   <= 1'b0;
            tval      <= TVAL_IDLE;
            timer_irq <= 1'b0;
        end else begin
            if (tcfg_we) begin
                tcfg_en <= tcfg_nx[0];
            end
            // load initval * 4 on enable, else count down
            if (tcfg_we && tcfg_nx[0]) begin
                tval <= {tcfg_nx[31:2], 2'b00};
            end else if (counting) begin
                if (tval == '0) begin
                    tval <= tcfg_periodic ? {tcfg_initval, 2'b00} : TVAL_IDLE;
                end else begin
                    tval <= tval - 1'b1;
                end
            end
            // expiry wins over a clear in the same cycle
            if (counting && tval == '0) begin
                timer_irq <= 1'b1;
            end else if (ticlr_clr) begin
                timer_irq <= 1'b0;
            end
        end
    end

    always_comb begin
        case (acc_num)
            CSR_TCFG: tmr_rvalue = tcfg_r;
            CSR_TVAL: tmr_rvalue = tval;
            default:  tmr_rvalue = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/csr_unit_top.sv ====
`default_nettype none

module csr_unit_top
    import csr_map_pkg::*;
    import exc_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  req,
    input  wire csr_op_e               op,
    input  wire logic [CSR_NUM_W-1:0]  num,
    input  wire logic [DATA_W-1:0]     wdata,
    input  wire logic [DATA_W-1:0]     wmask,
    input  wire logic                  wb_ex,
    input  wire logic [ECODE_W-1:0]    wb_ecode,
    input  wire logic [ESUBCODE_W-1:0] wb_esubcode,
    input  wire logic [DATA_W-1:0]     wb_pc,
    input  wire logic [DATA_W-1:0]     wb_vaddr,
    input  wire logic                  ertn_flush,
    input  wire logic [HWI_W-1:0]      hw_int,
    input  wire logic [DATA_W-1:0]     core_id,
    output logic                       ack,
    output logic [DATA_W-1:0]          rdata,
    output logic                       redirect_valid,
    output logic [DATA_W-1:0]          redirect_pc,
    output logic                       int_req
);

    // single-cycle access bus
    logic [CSR_NUM_W-1:0] acc_num;
    logic                 acc_we;
    logic [DATA_W-1:0]    acc_wvalue;
    logic [DATA_W-1:0]    acc_wmask;
    logic [DATA_W-1:0]    reg_rvalue;
    logic [DATA_W-1:0]    tmr_rvalue;

    // state feeding the trap logic
    logic                 timer_irq;
    logic                 crmd_ie;
    logic [DATA_W-1:0]    era;
    logic [DATA_W-1:0]    eentry;
    logic [LIE_W-1:0]     estat_is_lie;

    csr_access_port port_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .num        (num),
        .wdata      (wdata),
        .wmask      (wmask),
        .reg_rvalue (reg_rvalue),
        .tmr_rvalue (tmr_rvalue),
        .ack        (ack),
        .rdata      (rdata),
        .acc_num    (acc_num),
        .acc_we     (acc_we),
        .acc_wvalue (acc_wvalue),
        .acc_wmask  (acc_wmask)
    );

    csr_regfile regfile_i (
        .clk          (clk),
        .reset        (reset),
        .acc_num      (acc_num),
        .acc_we       (acc_we),
        .acc_wvalue   (acc_wvalue),
        .acc_wmask    (acc_wmask),
        .wb_ex        (wb_ex),
        .wb_ecode     (wb_ecode),
        .wb_esubcode  (wb_esubcode),
        .wb_pc        (wb_pc),
        .wb_vaddr     (wb_vaddr),
        .ertn_flush   (ertn_flush),
        .hw_int       (hw_int),
        .core_id      (core_id),
        .timer_irq    (timer_irq),
        .reg_rvalue   (reg_rvalue),
        .crmd_ie      (crmd_ie),
        .era          (era),
        .eentry       (eentry),
        .estat_is_lie (estat_is_lie)
    );

    csr_timer timer_i (
        .clk        (clk),
        .reset      (reset),
        .acc_num    (acc_num),
        .acc_we     (acc_we),
        .acc_wvalue (acc_wvalue),
        .acc_wmask  (acc_wmask),
        .tmr_rvalue (tmr_rvalue),
        .timer_irq  (timer_irq)
    );

    exc_ctrl exc_i (
        .clk            (clk),
        .reset          (reset),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .era            (era),
        .eentry         (eentry),
        .crmd_ie        (crmd_ie),
        .estat_is_lie   (estat_is_lie),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_req        (int_req)
    );

endmodule

`default_nettype wire

// ==== hdl/exc_ctrl.sv ====
`default_nettype none

module exc_ctrl
    import csr_map_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              wb_ex,
    input  wire logic              ertn_flush,
    input  wire logic [DATA_W-1:0] era,
    input  wire logic [DATA_W-1:0] eentry,
    input  wire logic              crmd_ie,
    input  wire logic [LIE_W-1:0]  estat_is_lie,
    output logic                   redirect_valid,
    output logic [DATA_W-1:0]      redirect_pc,
    output logic                   int_req
);

    // one-cycle redirect pulse after trap entry or ertn
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= wb_ex || ertn_flush;
        end
    end

    // exception target wins over ertn
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            redirect_pc <= eentry;
        end else if (ertn_flush) begin
            redirect_pc <= era;
        end
    end

    // any enabled pending line while interrupts are on
    assign int_req = crmd_ie && (|estat_is_lie);

endmodule

`default_nettype wire

// ==== hdl/exc_pkg.sv ====
`default_nettype none

package exc_pkg;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    // exception codes reported by writeback
    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } exc_code_e;

    // fetch address error sub-code
    localparam logic [ESUBCODE_W-1:0] ESUB_ADEF = 9'h0;

    // csr access operations
    typedef enum logic [1:0] {
        CSR_OP_RD,
        CSR_OP_WR,
        CSR_OP_XCHG
    } csr_op_e;

endpackage

`default_nettype wire

// ==== project.f ====
hdl/csr_map_pkg.sv
hdl/exc_pkg.sv
hdl/csr_access_port.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/exc_ctrl.sv
hdl/csr_unit_top.sv
verif/csr_unit_tb.sv

// ==== verif/csr_unit_tb.sv ====
`default_nettype none

module csr_unit_tb
    import csr_map_pkg::*;
    import exc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int MASK_CYCLES   = 500;
    localparam int EXC_CYCLES    = 300;
    localparam int TIMER_CYCLES  = 400;
    localparam int HWI_CYCLES    = 200;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MASK_CYCLES + EXC_CYCLES
                                     + TIMER_CYCLES + HWI_CYCLES + MARGIN_CYCLES;

    localparam logic [CSR_NUM_W-1:0] MASKED_REGS [8] = '{
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3,
        CSR_ERA, CSR_EENTRY, CSR_ECFG, CSR_CRMD
    };

    logic                  clk;
    logic                  reset;
    logic                  req;
    csr_op_e               op;
    logic [CSR_NUM_W-1:0]  num;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     wmask;
    logic                  wb_ex;
    logic [ECODE_W-1:0]    wb_ecode;
    logic [ESUBCODE_W-1:0] wb_esubcode;
    logic [DATA_W-1:0]     wb_pc;
    logic [DATA_W-1:0]     wb_vaddr;
    logic                  ertn_flush;
    logic [HWI_W-1:0]      hw_int;
    logic [DATA_W-1:0]     core_id;
    logic                  ack;
    logic [DATA_W-1:0]     rdata;
    logic                  redirect_valid;
    logic [DATA_W-1:0]     redirect_pc;
    logic                  int_req;

    // shadow copy of the register map, indexed by csr number
    logic [DATA_W-1:0] shadow [0:127];
    int seed = 32'h5375b941;

    csr_unit_top dut_i (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .op             (op),
        .num            (num),
        .wdata          (wdata),
        .wmask          (wmask),
        .wb_ex          (wb_ex),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .wb_vaddr       (wb_vaddr),
        .ertn_flush     (ertn_flush),
        .hw_int         (hw_int),
        .core_id        (core_id),
        .ack            (ack),
        .rdata          (rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_req        (int_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired, the run hung");
        $display("Done: errors found");
        $fatal(1);
    end

    // ack drops on the edge after req is seen low
    ack_release: assert property (@(posedge clk) disable iff (reset) $fell(req) |=> !ack)
        else begin
            $display("FAILED at %0t: ack expected 0 got 1", $time);
            $display("Done: errors found");
            $fatal(1);
        end

    // redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (reset)
                                     redirect_valid |=> !redirect_valid)
        else begin
            $display("FAILED at %0t: redirect_valid expected 0 got 1", $time);
            $display("Done: errors found");
            $fatal(1);
        end

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        assert (act === exp) else begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // bits that hold state, the rest read zero
    function automatic logic [DATA_W-1:0] stored_bits(input logic [CSR_NUM_W-1:0] n);
        case (n)
            CSR_CRMD, CSR_PRMD: return 32'h0000_0007;
            CSR_ECFG:           return 32'h0000_1bff;
            CSR_EENTRY:         return 32'hffff_ffc0;
            CSR_TICLR:          return 32'h0;
            default:            return 32'hffff_ffff;
        endcase
    endfunction

    task automatic csr_access(input csr_op_e o, input logic [CSR_NUM_W-1:0] n,
                              input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] m,
                              output logic [DATA_W-1:0] old);
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        num   <= n;
        wdata <= d;
        wmask <= m;
        @(negedge clk);
        while (!ack) @(negedge clk);
        old = rdata;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic write_csr(input csr_op_e o, input logic [CSR_NUM_W-1:0] n,
                             input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] m);
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] eff;
        csr_access(o, n, d, m, got);
        if (!$isunknown(shadow[n])) begin
            check_value($sformatf("rdata of csr 0x%0h", n), shadow[n], got);
        end
        eff = (o == CSR_OP_WR) ? '1 : m;
        shadow[n] = ((shadow[n] & ~eff) | (d & eff)) & stored_bits(n);
        // crmd.da is fixed at 1
        if (n == CSR_CRMD) begin
            shadow[n] = shadow[n] | 32'h8;
        end
    endtask

    task automatic read_check(input logic [CSR_NUM_W-1:0] n);
        logic [DATA_W-1:0] got;
        csr_access(CSR_OP_RD, n, '0, '0, got);
        check_value($sformatf("csr 0x%0h", n), shadow[n], got);
    endtask

    task automatic raise_exception(input exc_code_e code, input logic [ESUBCODE_W-1:0] esub,
                                   input logic [DATA_W-1:0] pc, input logic [DATA_W-1:0] va);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= code;
        wb_esubcode <= esub;
        wb_pc       <= pc;
        wb_vaddr    <= va;
        @(posedge clk);
        wb_ex <= 1'b0;
        @(negedge clk);
        check_value("redirect_valid", 1, redirect_valid);
        check_value("redirect_pc", shadow[CSR_EENTRY], redirect_pc);
        @(negedge clk);
        check_value("redirect_valid", 0, redirect_valid);
    endtask

    task automatic do_ertn();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
        @(negedge clk);
        check_value("redirect_valid", 1, redirect_valid);
        check_value("redirect_pc", shadow[CSR_ERA], redirect_pc);
        @(negedge clk);
        check_value("redirect_valid", 0, redirect_valid);
        shadow[CSR_CRMD] = (shadow[CSR_PRMD] & 32'h7) | 32'h8;
    endtask

    task automatic masked_access_test();
        csr_op_e           o;
        logic [DATA_W-1:0] got;
        foreach (MASKED_REGS[i]) begin
            write_csr(CSR_OP_WR, MASKED_REGS[i], $random(seed), '0);
            repeat (4) begin
                o = ($random(seed) & 1) ? CSR_OP_XCHG : CSR_OP_WR;
                write_csr(o, MASKED_REGS[i], $random(seed), $random(seed));
                read_check(MASKED_REGS[i]);
            end
        end
        // reserved bits stay zero
        write_csr(CSR_OP_WR, CSR_ECFG, '1, '0);
        csr_access(CSR_OP_RD, CSR_ECFG, '0, '0, got);
        check_value("ecfg", 32'h0000_1bff, got);
        write_csr(CSR_OP_WR, CSR_EENTRY, '1, '0);
        csr_access(CSR_OP_RD, CSR_EENTRY, '0, '0, got);
        check_value("eentry", 32'hffff_ffc0, got);
    endtask

    task automatic trap_and_return(input exc_code_e code, input logic [ESUBCODE_W-1:0] esub);
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] va;
        logic [DATA_W-1:0] got;
        pc = $random(seed);
        va = $random(seed);
        // enter from plv 3 with interrupts on
        write_csr(CSR_OP_WR, CSR_CRMD, 32'h7, '0);
        write_csr(CSR_OP_WR, CSR_EENTRY, $random(seed), '0);
        raise_exception(code, esub, pc, va);
        shadow[CSR_PRMD] = shadow[CSR_CRMD] & 32'h7;
        shadow[CSR_CRMD] = 32'h8;
        shadow[CSR_ERA]  = pc;
        // badv keeps its value for other codes
        if (code == ECODE_ALE) begin
            shadow[CSR_BADV] = va;
        end else if (code == ECODE_ADE && esub == ESUB_ADEF) begin
            shadow[CSR_BADV] = pc;
        end
        read_check(CSR_CRMD);
        read_check(CSR_PRMD);
        read_check(CSR_ERA);
        read_check(CSR_BADV);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.esubcode/ecode", {esub, code}, got[30:16]);
        do_ertn();
        read_check(CSR_CRMD);
    endtask

    task automatic timer_test();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] prev;
        int                init;
        init = ($random(seed) & 7) + 8;
        write_csr(CSR_OP_WR, CSR_ECFG, 32'h800, '0);
        write_csr(CSR_OP_WR, CSR_CRMD, 32'h4, '0);
        // one-shot run
        write_csr(CSR_OP_WR, CSR_TCFG, (init << 2) | 1, '0);
        prev = init * 4;
        repeat (4) begin
            csr_access(CSR_OP_RD, CSR_TVAL, '0, '0, got);
            assert (got <= prev) else begin
                $display("FAILED at %0t: tval expected <= %h got %h", $time, prev, got);
                $display("Done: errors found");
                $fatal(1);
            end
            prev = got;
        end
        repeat (init * 4 + 8) @(posedge clk);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.is[11]", 1, got[TIMER_IS_BIT]);
        csr_access(CSR_OP_RD, CSR_TVAL, '0, '0, got);
        check_value("tval", TVAL_IDLE, got);
        check_value("int_req", 1, int_req);
        write_csr(CSR_OP_WR, CSR_TICLR, 32'h1, '0);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.is[11]", 0, got[TIMER_IS_BIT]);
        check_value("int_req", 0, int_req);
        // periodic run fires again after a clear
        write_csr(CSR_OP_WR, CSR_TCFG, (init << 2) | 3, '0);
        repeat (init * 4 + 8) @(posedge clk);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.is[11]", 1, got[TIMER_IS_BIT]);
        write_csr(CSR_OP_WR, CSR_TICLR, 32'h1, '0);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.is[11]", 0, got[TIMER_IS_BIT]);
        repeat (init * 4 + 8) @(posedge clk);
        csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
        check_value("estat.is[11]", 1, got[TIMER_IS_BIT]);
        write_csr(CSR_OP_WR, CSR_TCFG, '0, '0);
        write_csr(CSR_OP_WR, CSR_TICLR, 32'h1, '0);
        check_value("int_req", 0, int_req);
    endtask

    task automatic hw_int_test();
        logic [DATA_W-1:0] got;
        logic [HWI_W-1:0]  lines;
        logic              exp_int;
        repeat (8) begin
            write_csr(CSR_OP_WR, CSR_CRMD, $random(seed) & 32'h7, '0);
            write_csr(CSR_OP_WR, CSR_ECFG, $random(seed), '0);
            lines = $random(seed);
            @(posedge clk);
            hw_int <= lines;
            csr_access(CSR_OP_RD, CSR_ESTAT, '0, '0, got);
            check_value("estat.is[9:2]", lines, got[9:2]);
            exp_int = shadow[CSR_CRMD][2] && |({lines, 2'b00} & shadow[CSR_ECFG][9:0]);
            check_value("int_req", exp_int, int_req);
        end
        @(posedge clk);
        hw_int <= '0;
    endtask

    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        op          = CSR_OP_RD;
        num         = '0;
        wdata       = '0;
        wmask       = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int      = '0;
        core_id     = 32'h0000_0002;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // reset state
        check_value("ack", 0, ack);
        check_value("redirect_valid", 0, redirect_valid);
        check_value("int_req", 0, int_req);
        shadow[CSR_CRMD] = 32'h8;
        shadow[CSR_ECFG] = '0;
        shadow[CSR_TVAL] = TVAL_IDLE;
        shadow[CSR_TID]  = core_id;
        read_check(CSR_CRMD);
        read_check(CSR_ECFG);
        read_check(CSR_TVAL);
        read_check(CSR_TID);

        masked_access_test();
        trap_and_return(ECODE_ALE, 9'h0);
        trap_and_return(ECODE_ADE, ESUB_ADEF);
        trap_and_return(ECODE_BRK, 9'h0);
        timer_test();
        hw_int_test();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
